/* include/hps_defs.svh */
`ifndef HPS_DEFS_SVH
`define HPS_DEFS_SVH

// ============================================================
// Host command port
// ============================================================

// Host data word
`define HPS_IO_WIDTH     16

// Board LEDs, mask and state share one host word
`define HPS_LED_WIDTH    8

// Flops between the host pins and clk_sys logic
`define HPS_SYNC_STAGES  2

// ============================================================
// Audio path
// ============================================================

`define HPS_AUDIO_WIDTH  16

// Top bit mutes, lower bits give the right shift
`define HPS_VOL_WIDTH    5

`endif

/* rtl/hps_pkg.sv */
package hps_pkg;

	// Host command opcodes, anything else is ignored
	typedef enum logic [7:0] {
		op_led_ctl = 8'h25,
		op_vol_att = 8'h26
	} host_opcode_e;

	// Decoder waits for the opcode word, then takes data words
	typedef enum logic {
		st_idle,
		st_data
	} cmd_state_e;

	// Amount of the other channel blended into each channel
	typedef enum logic [1:0] {
		mix_none,
		mix_eighth,
		mix_quarter,
		mix_half
	} mix_mode_e;

endpackage

/* rtl/host_io_sync.sv */
`timescale 1ns/100ps
`include "hps_defs.svh"

module host_io_sync (
	input  logic                     clk_sys,
	input  logic                     resetd,
	input  logic                     io_clk,
	input  logic                     io_uio,
	input  logic [`HPS_IO_WIDTH-1:0] io_din,
	output logic                     strobe,
	output logic                     uio,
	output logic [`HPS_IO_WIDTH-1:0] din,
	output logic                     io_ack
);

	// Bit 0 samples the pins, the top bit feeds the logic
	logic [`HPS_SYNC_STAGES-1:0] clk_sync;
	logic [`HPS_SYNC_STAGES-1:0] uio_sync;
	logic [`HPS_IO_WIDTH-1:0]    din_sync [`HPS_SYNC_STAGES];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_sync <= '0;
			uio_sync <= '0;
		end else begin
			clk_sync <= {clk_sync[`HPS_SYNC_STAGES-2:0], io_clk};
			uio_sync <= {uio_sync[`HPS_SYNC_STAGES-2:0], io_uio};
		end
	end

	// Data word moves with io_clk so all three stay aligned
	always_ff @(posedge clk_sys) begin
		din_sync[0] <= io_din;
		for (int i = 1; i < `HPS_SYNC_STAGES; i++) begin
			din_sync[i] <= din_sync[i-1];
		end
	end

	assign uio = uio_sync[`HPS_SYNC_STAGES-1];
	assign din = din_sync[`HPS_SYNC_STAGES-1];

	// io_ack doubles as the previous io_clk for edge detection
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_ack <= 1'b0;
			strobe <= 1'b0;
		end else begin
			io_ack <= clk_sync[`HPS_SYNC_STAGES-1];
			strobe <= clk_sync[`HPS_SYNC_STAGES-1] & ~io_ack;
		end
	end

	// One decoder write per host word
	a_strobe_single : assert property (
		@(posedge clk_sys) disable iff (resetd) strobe |=> !strobe
	);

endmodule

/* rtl/host_cmd_regs.sv */
`timescale 1ns/100ps
`include "hps_defs.svh"

module host_cmd_regs (
	input  logic                      clk_sys,
	input  logic                      resetd,
	input  logic                      strobe,
	input  logic                      uio,
	input  logic [`HPS_IO_WIDTH-1:0]  din,
	input  logic [`HPS_LED_WIDTH-1:0] led_status,
	output logic [`HPS_VOL_WIDTH-1:0] vol_att,
	output logic [`HPS_LED_WIDTH-1:0] led
);

	hps_pkg::cmd_state_e       state;
	hps_pkg::host_opcode_e     opcode;
	logic                      opcode_load;
	logic [`HPS_LED_WIDTH-1:0] led_mask;
	logic [`HPS_LED_WIDTH-1:0] led_state;

	// ============================================================
	// Command FSM
	// ============================================================

	// First strobe of a command carries the opcode
	assign opcode_load = uio && strobe && (state == hps_pkg::st_idle);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state <= hps_pkg::st_idle;
		end else if (!uio) begin
			// Host dropped uio, command is over
			state <= hps_pkg::st_idle;
		end else if (opcode_load) begin
			state <= hps_pkg::st_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (opcode_load) begin
			opcode <= hps_pkg::host_opcode_e'(din[7:0]);
		end
	end

	// ============================================================
	// Register writes
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			led_mask  <= '0;
			led_state <= '0;
			vol_att   <= '0;
		end else if (uio && strobe && (state == hps_pkg::st_data)) begin
			case (opcode)
				hps_pkg::op_led_ctl: begin
					// High byte is the mask, low byte the state
					{led_mask, led_state} <= din;
				end
				hps_pkg::op_vol_att: begin
					vol_att <= din[`HPS_VOL_WIDTH-1:0];
				end
				default: begin
					// Unknown opcode, data words dropped
				end
			endcase
		end
	end

	// ============================================================
	// LED outputs
	// ============================================================

	// Masked bits show the host state, the rest show board status
	assign led = (led_mask & led_state) | (~led_mask & led_status);

	a_vol_known : assert property (
		@(posedge clk_sys) disable iff (resetd) !$isunknown(vol_att)
	);

endmodule

/* rtl/audio_mixer.sv */
`timescale 1ns/100ps
`include "hps_defs.svh"

module audio_mixer (
	input  logic                        clk_sys,
	input  logic                        resetd,
	input  logic [`HPS_AUDIO_WIDTH-1:0] audio_l_in,
	input  logic [`HPS_AUDIO_WIDTH-1:0] audio_r_in,
	input  logic                        audio_signed,
	input  hps_pkg::mix_mode_e          mix_mode,
	output logic [`HPS_AUDIO_WIDTH-1:0] mix_l,
	output logic [`HPS_AUDIO_WIDTH-1:0] mix_r,
	output logic                        mix_signed
);

	localparam int AW = `HPS_AUDIO_WIDTH;

	logic [AW-1:0] next_l;
	logic [AW-1:0] next_r;

	// Arithmetic shift for signed samples, logical otherwise
	function automatic logic [AW-1:0] shr(
		input logic [AW-1:0] v,
		input logic [1:0]    n,
		input logic          sgn
	);
		logic signed [AW-1:0] sv;
		sv = v;
		if (sgn) begin
			shr = sv >>> n;
		end else begin
			shr = v >> n;
		end
	endfunction

	// o is the channel being built, p the opposite one
	function automatic logic [AW-1:0] mix_chan(
		input logic [AW-1:0]       o,
		input logic [AW-1:0]       p,
		input hps_pkg::mix_mode_e  mode,
		input logic                sgn
	);
		case (mode)
			hps_pkg::mix_eighth:  mix_chan = o - shr(o, 2'd3, sgn) + shr(p, 2'd3, sgn);
			hps_pkg::mix_quarter: mix_chan = o - shr(o, 2'd2, sgn) + shr(p, 2'd2, sgn);
			hps_pkg::mix_half:    mix_chan = shr(o, 2'd1, sgn) + shr(p, 2'd1, sgn);
			default:              mix_chan = o;
		endcase
	endfunction

	// Same rule both ways, results wrap to the sample width
	assign next_l = mix_chan(audio_l_in, audio_r_in, mix_mode, audio_signed);
	assign next_r = mix_chan(audio_r_in, audio_l_in, mix_mode, audio_signed);

	// ============================================================
	// Stage register
	// ============================================================

	// Flag travels with its sample pair
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mix_l      <= '0;
			mix_r      <= '0;
			mix_signed <= 1'b0;
		end else begin
			mix_l      <= next_l;
			mix_r      <= next_r;
			mix_signed <= audio_signed;
		end
	end

endmodule

/* rtl/audio_attenuator.sv */
`timescale 1ns/100ps
`include "hps_defs.svh"

module audio_attenuator (
	input  logic                        clk_sys,
	input  logic                        resetd,
	input  logic [`HPS_AUDIO_WIDTH-1:0] mix_l,
	input  logic [`HPS_AUDIO_WIDTH-1:0] mix_r,
	input  logic                        mix_signed,
	input  logic [`HPS_VOL_WIDTH-1:0]   vol_att,
	output logic [`HPS_AUDIO_WIDTH-1:0] audio_l,
	output logic [`HPS_AUDIO_WIDTH-1:0] audio_r
);

	localparam int AW = `HPS_AUDIO_WIDTH;
	localparam int SW = `HPS_VOL_WIDTH - 1;

	logic          mute;
	logic [SW-1:0] shift;

	assign mute  = vol_att[SW];
	assign shift = vol_att[SW-1:0];

	// Volume step is a right shift, sign kept for signed samples
	function automatic logic [AW-1:0] attenuate(
		input logic [AW-1:0] v,
		input logic [SW-1:0] n,
		input logic          sgn
	);
		logic signed [AW-1:0] sv;
		sv = v;
		if (sgn) begin
			attenuate = sv >>> n;
		end else begin
			attenuate = v >> n;
		end
	endfunction

	always_ff @(posedge clk_sys) begin
		if (resetd || mute) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= attenuate(mix_l, shift, mix_signed);
			audio_r <= attenuate(mix_r, shift, mix_signed);
		end
	end

	a_mute_silent : assert property (
		@(posedge clk_sys) disable iff (resetd)
		mute |=> (audio_l == '0) && (audio_r == '0)
	);

endmodule

/* rtl/hps_audio_top.sv */
`timescale 1ns/100ps
`include "hps_defs.svh"

module hps_audio_top (
	input  logic                        clk_sys,
	input  logic                        resetd,
	input  logic                        io_clk,
	input  logic                        io_uio,
	input  logic [`HPS_IO_WIDTH-1:0]    io_din,
	output logic                        io_ack,
	input  logic [`HPS_LED_WIDTH-1:0]   led_status,
	output logic [`HPS_LED_WIDTH-1:0]   led,
	input  logic [`HPS_AUDIO_WIDTH-1:0] audio_l_in,
	input  logic [`HPS_AUDIO_WIDTH-1:0] audio_r_in,
	input  logic                        audio_signed,
	input  hps_pkg::mix_mode_e          mix_mode,
	output logic [`HPS_AUDIO_WIDTH-1:0] audio_l,
	output logic [`HPS_AUDIO_WIDTH-1:0] audio_r
);

	// Host side
	logic                        strobe;
	logic                        uio;
	logic [`HPS_IO_WIDTH-1:0]    din;
	logic [`HPS_VOL_WIDTH-1:0]   vol_att;

	// Between the two audio stages
	logic [`HPS_AUDIO_WIDTH-1:0] mix_l;
	logic [`HPS_AUDIO_WIDTH-1:0] mix_r;
	logic                        mix_signed;

	// ============================================================
	// Host command port
	// ============================================================

	host_io_sync i_sync (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.io_clk  (io_clk),
		.io_uio  (io_uio),
		.io_din  (io_din),
		.strobe  (strobe),
		.uio     (uio),
		.din     (din),
		.io_ack  (io_ack)
	);

	host_cmd_regs i_cmd (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.strobe     (strobe),
		.uio        (uio),
		.din        (din),
		.led_status (led_status),
		.vol_att    (vol_att),
		.led        (led)
	);

	// ============================================================
	// Audio pipeline, two cycles input to output
	// ============================================================

	audio_mixer i_mix (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.audio_l_in   (audio_l_in),
		.audio_r_in   (audio_r_in),
		.audio_signed (audio_signed),
		.mix_mode     (mix_mode),
		.mix_l        (mix_l),
		.mix_r        (mix_r),
		.mix_signed   (mix_signed)
	);

	audio_attenuator i_att (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.mix_l      (mix_l),
		.mix_r      (mix_r),
		.mix_signed (mix_signed),
		.vol_att    (vol_att),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int period_ns    = 4,
	parameter int reset_cycles = 4
) (
	output logic clk_sys,
	output logic resetd
);

	initial begin
		clk_sys = 1'b0;
		forever #(period_ns / 2) clk_sys = ~clk_sys;
	end

	// Reset drops on a falling edge, away from the sampling edge
	initial begin
		resetd = 1'b1;
		repeat (reset_cycles) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;
	end

endmodule

/* verif/tb_hps_audio.sv */
`timescale 1ns/100ps
`include "hps_defs.svh"

module tb_hps_audio;

	localparam int clk_period_ns = 4;
	localparam int word_cycles   = 8;
	localparam int led_cmds      = 4;
	localparam int led_checks    = 20;
	localparam int mix_samples   = 300;
	localparam int vol_writes    = 6;
	localparam int vol_samples   = 200;
	// Idle before and after a command plus opcode and data words
	localparam int cmd_cycles    = 8 + 3 * word_cycles;
	localparam int planned_cycles = 32 + 3 * word_cycles
		+ (led_cmds + 1) * (cmd_cycles + 2 * led_checks)
		+ (mix_samples + 2)
		+ vol_writes * (cmd_cycles + vol_samples + 2);
	localparam longint timeout_ns = longint'(clk_period_ns) * 20 * planned_cycles;

	logic                        clk_sys;
	logic                        resetd;
	logic                        io_clk;
	logic                        io_uio;
	logic [`HPS_IO_WIDTH-1:0]    io_din;
	logic                        io_ack;
	logic [`HPS_LED_WIDTH-1:0]   led_status;
	logic [`HPS_LED_WIDTH-1:0]   led;
	logic [`HPS_AUDIO_WIDTH-1:0] audio_l_in;
	logic [`HPS_AUDIO_WIDTH-1:0] audio_r_in;
	logic                        audio_signed;
	hps_pkg::mix_mode_e          mix_mode;
	logic [`HPS_AUDIO_WIDTH-1:0] audio_l;
	logic [`HPS_AUDIO_WIDTH-1:0] audio_r;

	// Reference model state
	logic [`HPS_LED_WIDTH-1:0]   model_mask;
	logic [`HPS_LED_WIDTH-1:0]   model_state;
	logic [`HPS_VOL_WIDTH-1:0]   model_vol;
	logic [`HPS_AUDIO_WIDTH-1:0] exp_l_q[$];
	logic [`HPS_AUDIO_WIDTH-1:0] exp_r_q[$];
	logic [2:0]                  clk_hist;
	logic                        ack_check_on;
	logic                        ack_prev;
	int                          ack_rises;
	int                          words_sent;

	tb_clkgen #(.period_ns(clk_period_ns), .reset_cycles(4)) i_clkgen (
		.clk_sys (clk_sys),
		.resetd  (resetd)
	);

	hps_audio_top i_dut (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.io_clk       (io_clk),
		.io_uio       (io_uio),
		.io_din       (io_din),
		.io_ack       (io_ack),
		.led_status   (led_status),
		.led          (led),
		.audio_l_in   (audio_l_in),
		.audio_r_in   (audio_r_in),
		.audio_signed (audio_signed),
		.mix_mode     (mix_mode),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	// ============================================================
	// Reporting and reference model
	// ============================================================

	task automatic fail_run(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else
			fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Sample as an integer with the sign taken from the flag
	function automatic int widen(input logic [`HPS_AUDIO_WIDTH-1:0] s, input logic sgn);
		if (sgn)
			return int'($signed(s));
		return int'(s);
	endfunction

	function automatic logic [`HPS_AUDIO_WIDTH-1:0] model_mix(
			input logic [`HPS_AUDIO_WIDTH-1:0] own,
			input logic [`HPS_AUDIO_WIDTH-1:0] other,
			input hps_pkg::mix_mode_e mode,
			input logic sgn);
		int o;
		int p;
		int r;
		o = widen(own, sgn);
		p = widen(other, sgn);
		case (mode)
			hps_pkg::mix_eighth:  r = o - (o >>> 3) + (p >>> 3);
			hps_pkg::mix_quarter: r = o - (o >>> 2) + (p >>> 2);
			hps_pkg::mix_half:    r = (o >>> 1) + (p >>> 1);
			default:              r = o;
		endcase
		return r[`HPS_AUDIO_WIDTH-1:0];
	endfunction

	function automatic logic [`HPS_AUDIO_WIDTH-1:0] model_att(
			input logic [`HPS_AUDIO_WIDTH-1:0] mix,
			input logic [`HPS_VOL_WIDTH-1:0] vol,
			input logic sgn);
		int r;
		if (vol[`HPS_VOL_WIDTH-1])
			return '0;
		r = widen(mix, sgn) >>> vol[`HPS_VOL_WIDTH-2:0];
		return r[`HPS_AUDIO_WIDTH-1:0];
	endfunction

	// Full-scale corners show up often enough to exercise wrapping
	function automatic logic [`HPS_AUDIO_WIDTH-1:0] random_sample();
		case ($urandom_range(0, 7))
			0:       return 16'h8000;
			1:       return 16'h7fff;
			2:       return 16'hffff;
			default: return 16'($urandom);
		endcase
	endfunction

	// ============================================================
	// Stimulus tasks start and end on a falling edge
	// ============================================================

	task automatic send_word(input logic [`HPS_IO_WIDTH-1:0] data);
		io_din = data;
		io_clk = 1'b1;
		repeat (word_cycles / 2) @(negedge clk_sys);
		io_clk = 1'b0;
		repeat (word_cycles / 2) @(negedge clk_sys);
		words_sent++;
	endtask

	task automatic send_cmd(input logic [7:0] op, input logic [`HPS_IO_WIDTH-1:0] data,
			input int n_data);
		repeat (4) @(negedge clk_sys);
		io_uio = 1'b1;
		send_word({8'($urandom), op});
		repeat (n_data) send_word(data);
		io_uio = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic check_led_cycles(input int n);
		logic [`HPS_LED_WIDTH-1:0] exp_led;
		for (int i = 0; i < n; i++) begin
			led_status = 8'($urandom);
			@(posedge clk_sys);
			// Each mask bit selects host state or board status
			for (int b = 0; b < `HPS_LED_WIDTH; b++)
				exp_led[b] = model_mask[b] ? model_state[b] : led_status[b];
			check_value("led", led, exp_led);
			@(negedge clk_sys);
		end
	endtask

	// Each new pair is compared two falling edges later
	task automatic run_audio(input int n);
		logic [`HPS_AUDIO_WIDTH-1:0] l;
		logic [`HPS_AUDIO_WIDTH-1:0] r;
		logic [`HPS_AUDIO_WIDTH-1:0] ml;
		logic [`HPS_AUDIO_WIDTH-1:0] mr;
		for (int i = 0; i < n + 2; i++) begin
			if (i >= 2) begin
				check_value("audio_l", audio_l, exp_l_q.pop_front());
				check_value("audio_r", audio_r, exp_r_q.pop_front());
			end
			if (i < n) begin
				l = random_sample();
				r = random_sample();
				audio_l_in   = l;
				audio_r_in   = r;
				audio_signed = 1'($urandom_range(0, 1));
				mix_mode     = hps_pkg::mix_mode_e'($urandom_range(0, 3));
				ml = model_mix(l, r, mix_mode, audio_signed);
				mr = model_mix(r, l, mix_mode, audio_signed);
				exp_l_q.push_back(model_att(ml, model_vol, audio_signed));
				exp_r_q.push_back(model_att(mr, model_vol, audio_signed));
			end
			@(negedge clk_sys);
		end
	endtask

	// io_ack must trail io_clk by three rising edges
	always @(posedge clk_sys) begin
		clk_hist <= {clk_hist[1:0], io_clk};
	end

	always @(negedge clk_sys) begin
		if (ack_check_on) begin
			check_value("io_ack", io_ack, clk_hist[2]);
			if (io_ack && !ack_prev)
				ack_rises++;
			ack_prev = io_ack;
		end
	end

	initial begin
		#(timeout_ns);
		fail_run($sformatf("Timeout: run did not finish within %0d ns", timeout_ns));
	end

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [7:0]                op;
		logic [`HPS_LED_WIDTH-1:0] mask;
		logic [`HPS_LED_WIDTH-1:0] state;
		logic [`HPS_VOL_WIDTH-1:0] vol;
		void'($urandom(4718));
		io_clk       = 1'b0;
		io_uio       = 1'b0;
		io_din       = '0;
		led_status   = '0;
		audio_l_in   = '0;
		audio_r_in   = '0;
		audio_signed = 1'b0;
		mix_mode     = hps_pkg::mix_none;
		model_mask   = '0;
		model_state  = '0;
		model_vol    = '0;
		clk_hist     = '0;
		ack_check_on = 1'b0;
		ack_prev     = 1'b0;
		ack_rises    = 0;
		words_sent   = 0;

		@(negedge resetd);
		@(negedge clk_sys);
		check_value("io_ack", io_ack, 1'b0);
		check_value("led", led, 8'h00);
		check_value("audio_l", audio_l, 16'h0000);
		check_value("audio_r", audio_r, 16'h0000);
		// Clear mask makes led mirror led_status
		check_led_cycles(4);

		@(posedge clk_sys);
		ack_check_on = 1'b1;
		@(negedge clk_sys);

		// Decoder ignores bare host words with uio low
		repeat (3) send_word(16'($urandom));

		for (int c = 0; c < led_cmds; c++) begin
			mask  = 8'($urandom);
			state = 8'($urandom);
			send_cmd(hps_pkg::op_led_ctl, {mask, state}, 1);
			model_mask  = mask;
			model_state = state;
			check_led_cycles(led_checks);
		end

		op = 8'($urandom);
		if (op == hps_pkg::op_led_ctl || op == hps_pkg::op_vol_att)
			op = 8'h00;
		send_cmd(op, 16'($urandom), 2);
		check_led_cycles(led_checks);

		run_audio(mix_samples);

		for (int w = 0; w < vol_writes; w++) begin
			vol = 5'($urandom);
			if (w == 0)
				vol[`HPS_VOL_WIDTH-1] = 1'b0;
			else if (w == 1)
				vol[`HPS_VOL_WIDTH-1] = 1'b1;
			send_cmd(hps_pkg::op_vol_att, {11'($urandom), vol}, 1);
			model_vol = vol;
			run_audio(vol_samples);
		end

		check_value("io_ack rising edges", ack_rises, words_sent);
		$display(">>> PASS");
		$finish;
	end

endmodule

/* build.f */
+incdir+include
rtl/hps_pkg.sv
rtl/host_io_sync.sv
rtl/host_cmd_regs.sv
rtl/audio_mixer.sv
rtl/audio_attenuator.sv
rtl/hps_audio_top.sv
verif/tb_clkgen.sv
verif/tb_hps_audio.sv
